/* files.f */
design/cpu_bus_pkg.sv
design/axi_pkg.sv
design/axi_bus_engine.sv
design/inst_cache.sv
design/data_cache.sv
design/mem_subsys_top.sv
sim/axi_mem_model.sv
sim/tb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it. The exit status is the test result.
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_mem_subsys -f files.f -o tb_mem_subsys
./obj_dir/tb_mem_subsys

/* sim/tb_mem_subsys.sv */
// Memory subsystem testbench with clock, reset, AXI memory models, directed tests and checks.
`timescale 1ns/1ps

module tb_mem_subsys;

    // 28 accesses rounded up, each well under 50 cycles with 3-cycle waits, times a margin of 10.
    localparam int num_accesses   = 40;
    localparam int access_cycles  = 50;
    localparam int timeout_cycles = num_accesses * access_cycles * 10;

    logic                  clk;
    logic                  rst_n;
    cpu_bus_pkg::cpu_req_t ibus_req;
    cpu_bus_pkg::cpu_rsp_t ibus_rsp;
    cpu_bus_pkg::cpu_req_t dbus_req;
    cpu_bus_pkg::cpu_rsp_t dbus_rsp;
    axi_pkg::axi_ar_t      ibus_ar;
    axi_pkg::axi_ar_t      ibus_aw;
    axi_pkg::axi_r_t       ibus_r;
    axi_pkg::axi_w_t       ibus_w;
    axi_pkg::axi_b_t       ibus_b;
    axi_pkg::axi_ar_t      dbus_ar;
    axi_pkg::axi_ar_t      dbus_aw;
    axi_pkg::axi_r_t       dbus_r;
    axi_pkg::axi_w_t       dbus_w;
    axi_pkg::axi_b_t       dbus_b;
    logic ibus_arvalid;
    logic ibus_arready;
    logic ibus_rvalid;
    logic ibus_rready;
    logic ibus_awvalid;
    logic ibus_awready;
    logic ibus_wvalid;
    logic ibus_wready;
    logic ibus_bvalid;
    logic ibus_bready;
    logic dbus_arvalid;
    logic dbus_arready;
    logic dbus_rvalid;
    logic dbus_rready;
    logic dbus_awvalid;
    logic dbus_awready;
    logic dbus_wvalid;
    logic dbus_wready;
    logic dbus_bvalid;
    logic dbus_bready;
    int   i_single;
    int   i_line;
    int   i_writes;
    int   d_single;
    int   d_line;
    int   d_writes;
    int   seed;
    int   cycle_count = 0;
    cpu_bus_pkg::word_t mirror [256];   // Expected memory, both buses.

    mem_subsys_top dut (.*);

    axi_mem_model u_imem (
        .clk (clk), .rst_n (rst_n),
        .ar (ibus_ar), .arvalid (ibus_arvalid), .arready (ibus_arready),
        .r (ibus_r), .rvalid (ibus_rvalid), .rready (ibus_rready),
        .aw (ibus_aw), .awvalid (ibus_awvalid), .awready (ibus_awready),
        .w (ibus_w), .wvalid (ibus_wvalid), .wready (ibus_wready),
        .b (ibus_b), .bvalid (ibus_bvalid), .bready (ibus_bready),
        .single_reads (i_single), .line_reads (i_line), .writes (i_writes)
    );

    axi_mem_model u_dmem (
        .clk (clk), .rst_n (rst_n),
        .ar (dbus_ar), .arvalid (dbus_arvalid), .arready (dbus_arready),
        .r (dbus_r), .rvalid (dbus_rvalid), .rready (dbus_rready),
        .aw (dbus_aw), .awvalid (dbus_awvalid), .awready (dbus_awready),
        .w (dbus_w), .wvalid (dbus_wvalid), .wready (dbus_wready),
        .b (dbus_b), .bvalid (dbus_bvalid), .bready (dbus_bready),
        .single_reads (d_single), .line_reads (d_line), .writes (d_writes)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
            abort_run($sformatf("Timeout: tests did not finish in %0d cycles.", timeout_cycles));
    end

    task automatic check_word(input string name, input cpu_bus_pkg::word_t got,
                              input cpu_bus_pkg::word_t exp);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    // Holds one request until stall drops, returns the word seen in that cycle.
    task automatic access(input logic on_dbus, input logic cached, input cpu_bus_pkg::wen_t wen,
                          input cpu_bus_pkg::addr_t addr, input cpu_bus_pkg::word_t wdata,
                          output cpu_bus_pkg::word_t rdata);
        cpu_bus_pkg::cpu_req_t req;
        cpu_bus_pkg::cpu_rsp_t rsp;
        req = '{en: 1'b1, wen: wen, addr: addr, wdata: wdata, cached: cached};
        @(posedge clk);
        #1;
        if (on_dbus) dbus_req = req;
        else ibus_req = req;
        do begin
            @(negedge clk);
            rsp = on_dbus ? dbus_rsp : ibus_rsp;
        end while (rsp.stall);
        rdata = rsp.rdata;
        @(posedge clk);
        #1;
        if (on_dbus) dbus_req.en = 1'b0;
        else ibus_req.en = 1'b0;
    endtask

    task automatic read_check(input logic on_dbus, input logic cached,
                              input cpu_bus_pkg::addr_t addr);
        cpu_bus_pkg::word_t got;
        access(on_dbus, cached, '0, addr, '0, got);
        check_word(on_dbus ? "dbus_rsp.rdata" : "ibus_rsp.rdata", got, mirror[addr[9:2]]);
    endtask

    task automatic write_word(input logic cached, input cpu_bus_pkg::wen_t wen,
                              input cpu_bus_pkg::addr_t addr, input cpu_bus_pkg::word_t wdata);
        cpu_bus_pkg::word_t ignored;
        access(1'b1, cached, wen, addr, wdata, ignored);
        for (int i = 0; i < 4; i++) begin
            if (wen[i]) mirror[addr[9:2]][8*i +: 8] = wdata[8*i +: 8];
        end
    endtask

    task automatic inst_miss_then_hit();
        int lines;
        int singles;
        lines   = i_line;
        singles = i_single;
        read_check(1'b0, 1'b1, 32'h0000_0044);   // Not line aligned.
        check_count("u_imem.line_reads", i_line - lines, 1);
        for (int k = 0; k < 4; k++) read_check(1'b0, 1'b1, 32'h0000_0040 + 4 * k);
        check_count("u_imem.line_reads", i_line - lines, 1);
        check_count("u_imem.single_reads", i_single - singles, 0);
    endtask

    task automatic uncached_reads();
        int i_before;
        int d_before;
        i_before = i_single;
        d_before = d_single;
        repeat (2) read_check(1'b0, 1'b0, 32'h0000_0088);
        repeat (2) read_check(1'b1, 1'b0, 32'h0000_0288);
        check_count("u_imem.single_reads", i_single - i_before, 2);
        check_count("u_dmem.single_reads", d_single - d_before, 2);
    endtask

    task automatic data_write_hit();
        int lines;
        int singles;
        int wrs;
        read_check(1'b1, 1'b1, 32'h0000_0210);
        lines   = d_line;
        singles = d_single;
        wrs     = d_writes;
        write_word(1'b1, 4'b0110, 32'h0000_0218, 32'ha5c3_7e19);
        check_count("u_dmem.writes", d_writes - wrs, 1);
        read_check(1'b1, 1'b1, 32'h0000_0218);
        check_count("u_dmem.line_reads", d_line - lines, 0);
        check_count("u_dmem.single_reads", d_single - singles, 0);
        check_word("u_dmem.mem", u_dmem.mem[8'h86], mirror[8'h86]);
    endtask

    task automatic data_write_miss();
        int lines;
        int wrs;
        lines = d_line;
        wrs   = d_writes;
        write_word(1'b1, 4'b1100, 32'h0000_0324, 32'h1234_5678);
        check_count("u_dmem.writes", d_writes - wrs, 1);
        check_count("u_dmem.line_reads", d_line - lines, 0);
        read_check(1'b1, 1'b1, 32'h0000_0324);   // No allocation, so this misses.
        check_count("u_dmem.line_reads", d_line - lines, 1);
    endtask

    task automatic conflict_eviction();
        int lines;
        for (int k = 0; k < 6; k++) begin
            lines = d_line;
            read_check(1'b1, 1'b1, (k % 2 == 1) ? 32'h0000_0354 : 32'h0000_0254);
            check_count("u_dmem.line_reads", d_line - lines, 1);
        end
    endtask

    task automatic parallel_reads();
        cpu_bus_pkg::word_t inst_word;
        cpu_bus_pkg::word_t data_word;
        for (int k = 0; k < 4; k++) begin
            fork
                access(1'b0, k != 3, '0, 32'h0000_00c8 + 16 * k, '0, inst_word);
                access(1'b1, k != 2, '0, 32'h0000_03c4 + 16 * k, '0, data_word);
            join
            check_word("ibus_rsp.rdata", inst_word, mirror[8'h32 + 4 * k]);
            check_word("dbus_rsp.rdata", data_word, mirror[8'hf1 + 4 * k]);
        end
    endtask

    initial begin
        seed = 32'h81c7043d;
        for (int k = 0; k < 256; k++) mirror[k] = $random(seed);
        ibus_req = '0;
        dbus_req = '0;
        rst_n    = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        inst_miss_then_hit();
        uncached_reads();
        data_write_hit();
        data_write_miss();
        conflict_eviction();
        parallel_reads();
        check_count("u_imem.writes", i_writes, 0);   // Instruction side never writes.
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* sim/axi_mem_model.sv */
// AXI slave memory of 256 words with random ready delays and transfer counters.
`timescale 1ns/1ps

module axi_mem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  axi_pkg::axi_ar_t ar,
    input  logic             arvalid,
    output logic             arready,
    output axi_pkg::axi_r_t  r,
    output logic             rvalid,
    input  logic             rready,
    input  axi_pkg::axi_ar_t aw,
    input  logic             awvalid,
    output logic             awready,
    input  axi_pkg::axi_w_t  w,
    input  logic             wvalid,
    output logic             wready,
    output axi_pkg::axi_b_t  b,
    output logic             bvalid,
    input  logic             bready,
    output int               single_reads,
    output int               line_reads,
    output int               writes
);

    cpu_bus_pkg::word_t mem [256];
    int                 seed;
    logic [1:0]         ar_wait;
    logic [1:0]         r_wait;
    logic [1:0]         aw_wait;
    logic [1:0]         w_wait;
    logic [1:0]         b_wait;
    logic               rd_active;
    logic [7:0]         rd_idx;
    logic [3:0]         rd_beat;
    logic [3:0]         rd_len;
    logic [1:0]         wr_stage;   // 0 waits for AW, 1 for W, 2 sends B.
    logic [7:0]         wr_idx;

    // Zero to three cycles.
    function automatic logic [1:0] ready_delay();
        return 2'($random(seed));
    endfunction

    initial begin
        seed = 32'h81c7043d;
        for (int i = 0; i < 256; i++) mem[i] = $random(seed);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready      <= 1'b0;
            rvalid       <= 1'b0;
            awready      <= 1'b0;
            wready       <= 1'b0;
            bvalid       <= 1'b0;
            r            <= '0;
            b            <= '0;
            ar_wait      <= 2'd0;
            r_wait       <= 2'd0;
            aw_wait      <= 2'd0;
            w_wait       <= 2'd0;
            b_wait       <= 2'd0;
            rd_active    <= 1'b0;
            rd_idx       <= 8'd0;
            rd_beat      <= 4'd0;
            rd_len       <= 4'd0;
            wr_stage     <= 2'd0;
            wr_idx       <= 8'd0;
            single_reads <= 0;
            line_reads   <= 0;
            writes       <= 0;
        end else begin
            if (!rd_active) begin
                if (arvalid && arready) begin
                    arready   <= 1'b0;
                    ar_wait   <= ready_delay();
                    rd_active <= 1'b1;
                    rd_idx    <= ar.addr[9:2];
                    rd_len    <= ar.len;
                    rd_beat   <= 4'd0;
                    if (ar.len == axi_pkg::len_line) line_reads <= line_reads + 1;
                    if (ar.len == axi_pkg::len_single) single_reads <= single_reads + 1;
                end else if (arvalid && ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else if (arvalid) begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end else if (rvalid && rready) begin
                rvalid  <= 1'b0;
                r_wait  <= ready_delay();
                rd_idx  <= rd_idx + 8'd1;   // INCR burst.
                rd_beat <= rd_beat + 4'd1;
                if (r.rlast) rd_active <= 1'b0;
            end else if (!rvalid && r_wait == 2'd0) begin
                rvalid <= 1'b1;
                r      <= '{rid: '0, rdata: mem[rd_idx], rresp: axi_pkg::resp_okay,
                            rlast: rd_beat == rd_len};
            end else if (!rvalid) begin
                r_wait <= r_wait - 2'd1;
            end

            case (wr_stage)
                2'd0: if (awvalid && awready) begin
                    awready  <= 1'b0;
                    aw_wait  <= ready_delay();
                    wr_idx   <= aw.addr[9:2];
                    writes   <= writes + 1;
                    wr_stage <= 2'd1;
                end else if (awvalid && aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else if (awvalid) begin
                    aw_wait <= aw_wait - 2'd1;
                end
                2'd1: if (wvalid && wready) begin
                    wready   <= 1'b0;
                    w_wait   <= ready_delay();
                    wr_stage <= 2'd2;
                    for (int i = 0; i < 4; i++) begin
                        if (w.wstrb[i]) mem[wr_idx][8*i +: 8] <= w.wdata[8*i +: 8];
                    end
                end else if (wvalid && w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else if (wvalid) begin
                    w_wait <= w_wait - 2'd1;
                end
                default: if (bvalid && bready) begin
                    bvalid   <= 1'b0;
                    b_wait   <= ready_delay();
                    wr_stage <= 2'd0;
                end else if (!bvalid && b_wait == 2'd0) begin
                    bvalid <= 1'b1;
                    b      <= '{bid: '0, bresp: axi_pkg::resp_okay};
                end else if (!bvalid) begin
                    b_wait <= b_wait - 2'd1;
                end
            endcase
        end
    end

endmodule

/* design/mem_subsys_top.sv */
// Memory side top level with instruction and data caches on separate AXI ports.
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_bus_pkg::cpu_req_t ibus_req,
    output cpu_bus_pkg::cpu_rsp_t ibus_rsp,
    input  cpu_bus_pkg::cpu_req_t dbus_req,
    output cpu_bus_pkg::cpu_rsp_t dbus_rsp,

    output axi_pkg::axi_ar_t      ibus_ar,
    output logic                  ibus_arvalid,
    input  logic                  ibus_arready,
    input  axi_pkg::axi_r_t       ibus_r,
    input  logic                  ibus_rvalid,
    output logic                  ibus_rready,
    output axi_pkg::axi_ar_t      ibus_aw,
    output logic                  ibus_awvalid,
    input  logic                  ibus_awready,
    output axi_pkg::axi_w_t       ibus_w,
    output logic                  ibus_wvalid,
    input  logic                  ibus_wready,
    input  axi_pkg::axi_b_t       ibus_b,
    input  logic                  ibus_bvalid,
    output logic                  ibus_bready,

    output axi_pkg::axi_ar_t      dbus_ar,
    output logic                  dbus_arvalid,
    input  logic                  dbus_arready,
    input  axi_pkg::axi_r_t       dbus_r,
    input  logic                  dbus_rvalid,
    output logic                  dbus_rready,
    output axi_pkg::axi_ar_t      dbus_aw,
    output logic                  dbus_awvalid,
    input  logic                  dbus_awready,
    output axi_pkg::axi_w_t       dbus_w,
    output logic                  dbus_wvalid,
    input  logic                  dbus_wready,
    input  axi_pkg::axi_b_t       dbus_b,
    input  logic                  dbus_bvalid,
    output logic                  dbus_bready
);

    // Instruction side never writes.
    assign ibus_aw      = '0;
    assign ibus_awvalid = 1'b0;
    assign ibus_w       = '0;
    assign ibus_wvalid  = 1'b0;
    assign ibus_bready  = 1'b0;

    inst_cache u_inst_cache (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (ibus_req),
        .cpu_rsp (ibus_rsp),
        .ar      (ibus_ar),
        .arvalid (ibus_arvalid),
        .arready (ibus_arready),
        .r       (ibus_r),
        .rvalid  (ibus_rvalid),
        .rready  (ibus_rready)
    );

    data_cache u_data_cache (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (dbus_req),
        .cpu_rsp (dbus_rsp),
        .ar      (dbus_ar),
        .arvalid (dbus_arvalid),
        .arready (dbus_arready),
        .r       (dbus_r),
        .rvalid  (dbus_rvalid),
        .rready  (dbus_rready),
        .aw      (dbus_aw),
        .awvalid (dbus_awvalid),
        .awready (dbus_awready),
        .w       (dbus_w),
        .wvalid  (dbus_wvalid),
        .wready  (dbus_wready),
        .b       (dbus_b),
        .bvalid  (dbus_bvalid),
        .bready  (dbus_bready)
    );

endmodule

/* design/data_cache.sv */
// Write-through, no-write-allocate direct-mapped data cache with byte enables and its AXI engine.
`timescale 1ns/1ps

module data_cache (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_bus_pkg::cpu_req_t cpu_req,
    output cpu_bus_pkg::cpu_rsp_t cpu_rsp,
    output axi_pkg::axi_ar_t      ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  axi_pkg::axi_r_t       r,
    input  logic                  rvalid,
    output logic                  rready,
    output axi_pkg::axi_ar_t      aw,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_pkg::axi_w_t       w,
    output logic                  wvalid,
    input  logic                  wready,
    input  axi_pkg::axi_b_t       b,
    input  logic                  bvalid,
    output logic                  bready
);

    cpu_bus_pkg::word_t data_q [cpu_bus_pkg::num_lines][cpu_bus_pkg::words_per_line];
    logic [cpu_bus_pkg::tag_bits-1:0]   tag_q [cpu_bus_pkg::num_lines];
    logic [cpu_bus_pkg::num_lines-1:0]  valid_q;
    cpu_bus_pkg::word_t                 hold_q;
    logic                               ready_q;
    logic                               fill_q;
    logic [cpu_bus_pkg::offset_bits-3:0] fill_cnt_q;

    logic [cpu_bus_pkg::index_bits-1:0]  idx;
    logic [cpu_bus_pkg::tag_bits-1:0]    tag;
    logic [cpu_bus_pkg::offset_bits-3:0] woff;
    logic hit;
    logic is_write;
    logic line_fill;
    logic stall;
    logic start;
    logic busy;
    logic beat_valid;
    logic done;
    cpu_bus_pkg::word_t beat_data;
    axi_pkg::eng_req_t  eng_req;

    assign idx       = cpu_req.addr[cpu_bus_pkg::offset_bits +: cpu_bus_pkg::index_bits];
    assign tag       = cpu_req.addr[31 -: cpu_bus_pkg::tag_bits];
    assign woff      = cpu_req.addr[cpu_bus_pkg::offset_bits-1:2];
    assign hit       = valid_q[idx] && tag_q[idx] == tag;
    assign is_write  = |cpu_req.wen;
    assign line_fill = cpu_req.cached && !is_write;

    // Every write goes to the bus.
    assign stall = cpu_req.en && (is_write || !cpu_req.cached || !hit) && !ready_q;
    assign start = stall && !busy;

    assign cpu_rsp = '{rdata: cpu_req.cached ? data_q[idx][woff] : hold_q, stall: stall};

    assign eng_req = '{write: is_write,
                       addr: line_fill ?
                             {cpu_req.addr[31:cpu_bus_pkg::offset_bits],
                              {cpu_bus_pkg::offset_bits{1'b0}}} : cpu_req.addr,
                       len: line_fill ? axi_pkg::len_line : axi_pkg::len_single,
                       wdata: cpu_req.wdata, wstrb: cpu_req.wen};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            ready_q    <= 1'b0;
            fill_q     <= 1'b0;
            fill_cnt_q <= '0;
        end else begin
            ready_q <= done;
            if (start) begin
                fill_q     <= line_fill;
                fill_cnt_q <= '0;
                if (line_fill) valid_q[idx] <= 1'b0;
            end else if (beat_valid) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
            end
            if (done && fill_q) valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && line_fill) tag_q[idx] <= tag;
        if (beat_valid && fill_q) data_q[idx][fill_cnt_q] <= beat_data;
        if (beat_valid && !fill_q) hold_q <= beat_data;
        // Write hit updates the line as it goes out. A miss leaves the cache alone.
        if (start && is_write && cpu_req.cached && hit) begin
            for (int i = 0; i < 4; i++) begin
                if (cpu_req.wen[i]) data_q[idx][woff][8*i +: 8] <= cpu_req.wdata[8*i +: 8];
            end
        end
    end

    axi_bus_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .req        (eng_req),
        .busy       (busy),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .done       (done),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .b          (b),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    // Core keeps its request steady through a stall.
    assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req.en && cpu_rsp.stall |=> $stable(cpu_req));

endmodule

/* design/inst_cache.sv */
// Read-only direct-mapped instruction cache with uncached bypass and its AXI read engine.
`timescale 1ns/1ps

module inst_cache (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_bus_pkg::cpu_req_t cpu_req,
    output cpu_bus_pkg::cpu_rsp_t cpu_rsp,
    output axi_pkg::axi_ar_t      ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  axi_pkg::axi_r_t       r,
    input  logic                  rvalid,
    output logic                  rready
);

    cpu_bus_pkg::word_t data_q [cpu_bus_pkg::num_lines][cpu_bus_pkg::words_per_line];
    logic [cpu_bus_pkg::tag_bits-1:0]   tag_q [cpu_bus_pkg::num_lines];
    logic [cpu_bus_pkg::num_lines-1:0]  valid_q;
    cpu_bus_pkg::word_t                 hold_q;   // Uncached word.
    logic                               ready_q;
    logic                               fill_q;
    logic [cpu_bus_pkg::offset_bits-3:0] fill_cnt_q;

    logic [cpu_bus_pkg::index_bits-1:0]  idx;
    logic [cpu_bus_pkg::tag_bits-1:0]    tag;
    logic [cpu_bus_pkg::offset_bits-3:0] woff;
    logic hit;
    logic stall;
    logic start;
    logic busy;
    logic beat_valid;
    logic done;
    cpu_bus_pkg::word_t beat_data;
    axi_pkg::eng_req_t  eng_req;

    assign idx  = cpu_req.addr[cpu_bus_pkg::offset_bits +: cpu_bus_pkg::index_bits];
    assign tag  = cpu_req.addr[31 -: cpu_bus_pkg::tag_bits];
    assign woff = cpu_req.addr[cpu_bus_pkg::offset_bits-1:2];
    assign hit  = valid_q[idx] && tag_q[idx] == tag;

    assign stall = cpu_req.en && (!cpu_req.cached || !hit) && !ready_q;
    assign start = stall && !busy;

    assign cpu_rsp = '{rdata: cpu_req.cached ? data_q[idx][woff] : hold_q, stall: stall};

    assign eng_req = '{write: 1'b0,
                       addr: cpu_req.cached ?
                             {cpu_req.addr[31:cpu_bus_pkg::offset_bits],
                              {cpu_bus_pkg::offset_bits{1'b0}}} : cpu_req.addr,
                       len: cpu_req.cached ? axi_pkg::len_line : axi_pkg::len_single,
                       wdata: '0, wstrb: '0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            ready_q    <= 1'b0;
            fill_q     <= 1'b0;
            fill_cnt_q <= '0;
        end else begin
            ready_q <= done;   // Result shows one cycle after done.
            if (start) begin
                fill_q     <= cpu_req.cached;
                fill_cnt_q <= '0;
                if (cpu_req.cached) valid_q[idx] <= 1'b0;
            end else if (beat_valid) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
            end
            if (done && fill_q) valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && cpu_req.cached) tag_q[idx] <= tag;
        if (beat_valid && fill_q) data_q[idx][fill_cnt_q] <= beat_data;
        if (beat_valid && !fill_q) hold_q <= beat_data;
    end

    axi_bus_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .req        (eng_req),
        .busy       (busy),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .done       (done),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready),
        .aw         (),
        .awvalid    (),
        .awready    (1'b0),
        .w          (),
        .wvalid     (),
        .wready     (1'b0),
        .b          ('0),
        .bvalid     (1'b0),
        .bready     ()
    );

    // Instruction fetch never writes.
    assert property (@(posedge clk) disable iff (!rst_n)
        cpu_req.en |-> cpu_req.wen == '0);

endmodule

/* design/axi_bus_engine.sv */
// AXI master engine running one read burst or single write at a time, with protocol checks.
`timescale 1ns/1ps

module axi_bus_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  axi_pkg::eng_req_t     req,
    output logic                  busy,
    output logic                  beat_valid,
    output cpu_bus_pkg::word_t    beat_data,
    output logic                  done,
    output axi_pkg::axi_ar_t      ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  axi_pkg::axi_r_t       r,
    input  logic                  rvalid,
    output logic                  rready,
    output axi_pkg::axi_ar_t      aw,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_pkg::axi_w_t       w,
    output logic                  wvalid,
    input  logic                  wready,
    input  axi_pkg::axi_b_t       b,
    input  logic                  bvalid,
    output logic                  bready
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp
    } state_t;

    state_t            state_q;
    axi_pkg::eng_req_t req_q;
    logic [3:0]        beat_q;
    axi_pkg::axi_ar_t  addr_fields;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            beat_q  <= '0;
        end else begin
            case (state_q)
                st_idle: if (start) begin
                    state_q <= st_addr;
                    beat_q  <= '0;
                end
                st_addr: if (req_q.write ? awready : arready) state_q <= st_data;
                st_data: if (req_q.write) begin
                    if (wready) state_q <= st_resp;
                end else if (rvalid) begin
                    beat_q <= beat_q + 4'd1;
                    if (r.rlast) state_q <= st_idle;
                end
                default: if (bvalid) state_q <= st_idle;   // Response phase.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state_q == st_idle) req_q <= req;
    end

    assign addr_fields = '{id: '0, addr: req_q.addr, len: req_q.len,
                           size: axi_pkg::size_word, burst: axi_pkg::burst_incr,
                           lock: '0, cache: '0, prot: '0};
    assign ar = addr_fields;
    assign aw = addr_fields;
    assign w  = '{wid: '0, wdata: req_q.wdata, wstrb: req_q.wstrb, wlast: 1'b1};

    assign arvalid = state_q == st_addr && !req_q.write;
    assign awvalid = state_q == st_addr && req_q.write;
    assign rready  = state_q == st_data && !req_q.write;
    assign wvalid  = state_q == st_data && req_q.write;
    assign bready  = state_q == st_resp;

    assign busy       = state_q != st_idle;
    assign beat_valid = rready && rvalid;
    assign beat_data  = r.rdata;
    assign done       = (beat_valid && r.rlast) || (bready && bvalid);

    // Address and data stay up and unchanged until accepted.
    assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar));
    assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw));
    assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w));

    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> r.rresp == axi_pkg::resp_okay && r.rid == '0);
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && bready |-> b.bresp == axi_pkg::resp_okay && b.bid == '0);

    // Slave must end the burst on the requested length.
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> r.rlast == (beat_q == req_q.len));

endmodule

/* design/axi_pkg.sv */
// AXI channel structs, fixed burst constants and the cache to bus engine request.
package axi_pkg;

    // Shared by the AR and AW channels.
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [3:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic [1:0]  lock;
        logic [3:0]  cache;
        logic [2:0]  prot;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  rid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rlast;
    } axi_r_t;

    typedef struct packed {
        logic [3:0]  wid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wlast;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] bid;
        logic [1:0] bresp;
    } axi_b_t;

    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [2:0] size_word  = 3'd2;
    localparam logic [1:0] resp_okay  = 2'b00;
    localparam logic [3:0] len_line   = 4'd3;
    localparam logic [3:0] len_single = 4'd0;

    // One transfer, handed from a cache to its engine.
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [3:0]  len;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } eng_req_t;

endpackage

/* design/cpu_bus_pkg.sv */
// Core-side address, data and byte-enable types, request and response structs, cache geometry.
package cpu_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wen_t;   // All zero is a read.

    // Driven by the core, held while stall is high.
    typedef struct packed {
        logic  en;
        wen_t  wen;
        addr_t addr;
        word_t wdata;
        logic  cached;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  stall;
    } cpu_rsp_t;

    // Direct-mapped, 16 lines of 4 words.
    localparam int words_per_line = 4;
    localparam int num_lines      = 16;
    localparam int offset_bits    = 4;
    localparam int index_bits     = 4;
    localparam int tag_bits       = 24;

endpackage
